//--- src/nar_pkg.sv
package nar_pkg;

        // sizes of the network
        localparam int n_taps = 16;
        localparam int n_hidden = 5;

        // Q2.6 fixed point
        localparam int frac_bits = 6;
        // rest value of the tap line is 0.375
        localparam int tap_rest = 24;
        // hard-tanh bound of 1.0
        localparam int act_limit = 64;

        // rom layout with w1 stored neuron-major
        localparam int rom_depth = 91;
        localparam int rom_b1_base = 0;
        localparam int rom_w1_base = 5;
        localparam int rom_b2_addr = 85;
        localparam int rom_w2_base = 86;

        typedef logic signed [7:0] sample_t;
        typedef logic signed [19:0] acc_t;
        typedef logic [3:0] tap_idx_t;

        // one entry per hidden neuron
        typedef sample_t [n_hidden-1:0] hidden_vec_t;
        // tap 0 is the newest sample
        typedef sample_t [n_taps-1:0] tap_vec_t;

        typedef enum logic [1:0] {
                st_idle,
                st_mac,
                st_act,
                st_sum
        } nar_state_t;

endpackage

//--- src/nar_ctrl.sv
`timescale 1ns/10ps

module nar_ctrl (
        input  logic clk,
        input  logic rst,
        input  logic enable,
        input  logic x_ready,
        input  logic tap_last,
        output logic accept,
        output logic mac_step,
        output logic act_load,
        output logic sum_load,
        output logic busy,
        output logic y_valid
);
        import nar_pkg::*;

        nar_state_t state;
        nar_state_t state_next;

        // new samples are only taken while idle
        assign accept = (state == st_idle) && x_ready && enable;
        assign mac_step = (state == st_mac);
        assign act_load = (state == st_act);
        assign sum_load = (state == st_sum);
        assign busy = (state != st_idle);

        always_comb begin
                state_next = state;
                case (state)
                        st_idle: begin
                                if (accept)
                                        state_next = st_mac;
                        end
                        st_mac: begin
                                if (tap_last)
                                        state_next = st_act;
                        end
                        st_act: begin
                                state_next = st_sum;
                        end
                        st_sum: begin
                                state_next = st_idle;
                        end
                        default: begin
                                state_next = st_idle;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= st_idle;
                        y_valid <= 1'b0;
                end else begin
                        // pulse follows the enabled output edge only
                        y_valid <= enable && sum_load;
                        if (enable)
                                state <= state_next;
                end
        end

        // one prediction per pulse, even across a pause
        valid_single_cycle: assert property (@(posedge clk) disable iff (rst)
                y_valid |=> !y_valid);

endmodule

//--- src/tap_counter.sv
`timescale 1ns/10ps

module tap_counter (
        input  logic clk,
        input  logic rst,
        input  logic enable,
        input  logic mac_step,
        output nar_pkg::tap_idx_t tap_idx,
        output logic tap_last
);
        import nar_pkg::*;

        assign tap_last = (tap_idx == tap_idx_t'(n_taps - 1));

        always_ff @(posedge clk) begin
                if (rst) begin
                        tap_idx <= '0;
                end else if (enable && mac_step) begin
                        // wraps back to tap 0 for the next sample
                        if (tap_last)
                                tap_idx <= '0;
                        else
                                tap_idx <= tap_idx + 1'b1;
                end
        end

        count_moves_on_step: assert property (@(posedge clk)
                !rst && !(enable && mac_step) |=> $stable(tap_idx));

endmodule

//--- src/weight_rom.sv
`timescale 1ns/10ps

module weight_rom (
        input  nar_pkg::tap_idx_t tap_idx,
        output nar_pkg::hidden_vec_t w1_col,
        output nar_pkg::hidden_vec_t b1_vec,
        output nar_pkg::hidden_vec_t w2_vec,
        output nar_pkg::sample_t b2
);
        import nar_pkg::*;

        sample_t rom [rom_depth];

        initial begin
                $readmemh("weights.hex", rom);
        end

        // output bias sits alone between the two weight groups
        assign b2 = rom[rom_b2_addr];

        always_comb begin
                for (int n = 0; n < n_hidden; n++) begin
                        b1_vec[n] = rom[rom_b1_base + n];
                        // each neuron owns n_taps consecutive words
                        w1_col[n] = rom[rom_w1_base + n * n_taps + int'(tap_idx)];
                        w2_vec[n] = rom[rom_w2_base + n];
                end
        end

endmodule

//--- src/tap_delay_line.sv
`timescale 1ns/10ps

module tap_delay_line (
        input  logic clk,
        input  logic rst,
        input  logic enable,
        input  logic accept,
        input  nar_pkg::sample_t x_in,
        output nar_pkg::tap_vec_t taps
);
        import nar_pkg::*;

        always_ff @(posedge clk) begin
                if (rst) begin
                        // history starts at the rest value, not at zero
                        for (int t = 0; t < n_taps; t++)
                                taps[t] <= sample_t'(tap_rest);
                end else if (enable && accept) begin
                        // older samples move one place up, oldest drops out
                        taps <= {taps[n_taps-2:0], x_in};
                end
        end

endmodule

//--- src/hidden_layer.sv
`timescale 1ns/10ps

module hidden_layer (
        input  logic clk,
        input  logic rst,
        input  logic enable,
        input  logic accept,
        input  logic mac_step,
        input  logic act_load,
        input  nar_pkg::tap_idx_t tap_idx,
        input  nar_pkg::tap_vec_t taps,
        input  nar_pkg::hidden_vec_t w1_col,
        input  nar_pkg::hidden_vec_t b1_vec,
        output nar_pkg::hidden_vec_t h_vec
);
        import nar_pkg::*;

        acc_t acc [n_hidden];
        acc_t prod [n_hidden];
        sample_t cur_tap;

        // scale back to Q2.6 and clamp to +-1.0
        function automatic sample_t hard_tanh(input acc_t a);
                acc_t s;
                s = a >>> frac_bits;
                if (s > acc_t'(act_limit))
                        return sample_t'(act_limit);
                else if (s < -acc_t'(act_limit))
                        return sample_t'(-act_limit);
                else
                        return sample_t'(s);
        endfunction

        assign cur_tap = taps[tap_idx];

        always_comb begin
                for (int n = 0; n < n_hidden; n++)
                        prod[n] = acc_t'(sample_t'(w1_col[n])) * acc_t'(cur_tap);
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        h_vec <= '0;
                        for (int n = 0; n < n_hidden; n++)
                                acc[n] <= '0;
                end else if (enable) begin
                        for (int n = 0; n < n_hidden; n++) begin
                                // bias enters pre-scaled so the sum keeps 12 fraction bits
                                if (accept)
                                        acc[n] <= acc_t'(sample_t'(b1_vec[n])) <<< frac_bits;
                                else if (mac_step)
                                        acc[n] <= acc[n] + prod[n];
                                if (act_load)
                                        h_vec[n] <= hard_tanh(acc[n]);
                        end
                end
        end

        for (genvar g = 0; g < n_hidden; g++) begin : g_bound
                act_in_range: assert property (@(posedge clk) disable iff (rst)
                        $signed(h_vec[g]) <= act_limit && $signed(h_vec[g]) >= -act_limit);
        end

endmodule

//--- src/output_layer.sv
`timescale 1ns/10ps

module output_layer (
        input  logic clk,
        input  logic rst,
        input  logic enable,
        input  logic sum_load,
        input  nar_pkg::hidden_vec_t h_vec,
        input  nar_pkg::hidden_vec_t w2_vec,
        input  nar_pkg::sample_t b2,
        output nar_pkg::sample_t y_out
);
        import nar_pkg::*;

        acc_t sum;
        acc_t scaled;
        sample_t y_sat;

        always_comb begin
                sum = acc_t'(b2) <<< frac_bits;
                for (int n = 0; n < n_hidden; n++)
                        sum = sum + acc_t'(sample_t'(w2_vec[n])) * acc_t'(sample_t'(h_vec[n]));
                scaled = sum >>> frac_bits;
                // saturate to the full Q2.6 range
                if (scaled > acc_t'(127))
                        y_sat = 8'sd127;
                else if (scaled < -acc_t'(128))
                        y_sat = -8'sd128;
                else
                        y_sat = sample_t'(scaled);
        end

        always_ff @(posedge clk) begin
                if (rst)
                        y_out <= '0;
                else if (enable && sum_load)
                        y_out <= y_sat;
        end

endmodule

//--- src/narnet_top.sv
`timescale 1ns/10ps

module narnet_top (
        input  logic clk,
        input  logic rst,
        input  logic enable,
        input  logic x_ready,
        input  nar_pkg::sample_t x_in,
        output nar_pkg::sample_t y_out,
        output logic y_valid,
        output logic busy
);
        import nar_pkg::*;

        logic accept;
        logic mac_step;
        logic act_load;
        logic sum_load;
        logic tap_last;
        tap_idx_t tap_idx;
        tap_vec_t taps;
        hidden_vec_t w1_col;
        hidden_vec_t b1_vec;
        hidden_vec_t w2_vec;
        hidden_vec_t h_vec;
        sample_t b2;

        nar_ctrl nar_ctrl_inst (
                .clk(clk), .rst(rst), .enable(enable), .x_ready(x_ready),
                .tap_last(tap_last), .accept(accept), .mac_step(mac_step),
                .act_load(act_load), .sum_load(sum_load), .busy(busy), .y_valid(y_valid)
        );

        tap_counter tap_counter_inst (
                .clk(clk), .rst(rst), .enable(enable), .mac_step(mac_step),
                .tap_idx(tap_idx), .tap_last(tap_last)
        );

        weight_rom weight_rom_inst (
                .tap_idx(tap_idx), .w1_col(w1_col), .b1_vec(b1_vec),
                .w2_vec(w2_vec), .b2(b2)
        );

        tap_delay_line tap_delay_line_inst (
                .clk(clk), .rst(rst), .enable(enable), .accept(accept),
                .x_in(x_in), .taps(taps)
        );

        hidden_layer hidden_layer_inst (
                .clk(clk), .rst(rst), .enable(enable), .accept(accept),
                .mac_step(mac_step), .act_load(act_load), .tap_idx(tap_idx),
                .taps(taps), .w1_col(w1_col), .b1_vec(b1_vec), .h_vec(h_vec)
        );

        output_layer output_layer_inst (
                .clk(clk), .rst(rst), .enable(enable), .sum_load(sum_load),
                .h_vec(h_vec), .w2_vec(w2_vec), .b2(b2), .y_out(y_out)
        );

endmodule

//--- bench/narnet_tb.sv
`timescale 1ns/10ps

module narnet_tb;
        import nar_pkg::*;

        localparam logic [31:0] seed = 32'h4c88_a881;
        // zero input, random, extremes, busy pulses, pauses, mid-stream reset
        localparam int n_samples = 1 + 200 + 32 + 20 + 30 + 6;
        localparam int timeout_cycles = 40 * n_samples + 200;
        // y_valid is sampled high at the edge 19 after the accepting edge
        localparam int valid_latency = 19;
        // output edge comes after the 16 mac edges and the activation edge
        localparam int last_count = n_taps + 1;

        logic clk;
        logic rst;
        logic enable;
        logic x_ready;
        sample_t x_in;
        sample_t y_out;
        logic y_valid;
        logic busy;

        logic [31:0] rng;
        sample_t wmem [rom_depth];
        int hist [n_taps];
        logic m_busy;
        logic m_valid;
        logic m_paused;
        int m_cnt;
        int m_pred;
        int m_acc_cycle;
        int cycle = 0;
        int err_value = 0;
        int err_timing = 0;
        int n_checked = 0;

        narnet_top narnet_top_inst (
                .clk(clk), .rst(rst), .enable(enable), .x_ready(x_ready),
                .x_in(x_in), .y_out(y_out), .y_valid(y_valid), .busy(busy)
        );

        initial begin
                $readmemh("weights.hex", wmem);
        end

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        function automatic logic [31:0] xorshift32(input logic [31:0] s);
                logic [31:0] r;
                r = s ^ (s << 13);
                r = r ^ (r >> 17);
                r = r ^ (r << 5);
                return r;
        endfunction

        task automatic next_rand(output logic [31:0] r);
                rng = xorshift32(rng);
                r = rng;
        endtask

        function automatic int clamp(input int v, input int lo, input int hi);
                if (v > hi)
                        return hi;
                if (v < lo)
                        return lo;
                return v;
        endfunction

        // reference prediction from the current history
        function automatic int predict();
                int acc;
                int h [n_hidden];
                for (int n = 0; n < n_hidden; n++) begin
                        acc = int'(wmem[rom_b1_base + n]) * (1 << frac_bits);
                        for (int t = 0; t < n_taps; t++)
                                acc += int'(wmem[rom_w1_base + n * n_taps + t]) * hist[t];
                        h[n] = clamp(acc >>> frac_bits, -act_limit, act_limit);
                end
                acc = int'(wmem[rom_b2_addr]) * (1 << frac_bits);
                for (int n = 0; n < n_hidden; n++)
                        acc += int'(wmem[rom_w2_base + n]) * h[n];
                return clamp(acc >>> frac_bits, -128, 127);
        endfunction

        // model of accept and output timing that counts enabled edges only
        always @(posedge clk) begin
                cycle = cycle + 1;
                m_valid = 1'b0;
                if (rst) begin
                        m_busy = 1'b0;
                        m_paused = 1'b0;
                        m_cnt = 0;
                        for (int t = 0; t < n_taps; t++)
                                hist[t] = tap_rest;
                end else if (enable) begin
                        if (!m_busy && x_ready) begin
                                for (int t = n_taps - 1; t > 0; t--)
                                        hist[t] = hist[t-1];
                                hist[0] = int'(x_in);
                                m_pred = predict();
                                m_busy = 1'b1;
                                m_paused = 1'b0;
                                m_cnt = 0;
                                m_acc_cycle = cycle;
                        end else if (m_busy && m_cnt == last_count) begin
                                m_busy = 1'b0;
                                m_valid = 1'b1;
                        end else if (m_busy) begin
                                m_cnt = m_cnt + 1;
                        end
                end else if (m_busy) begin
                        m_paused = 1'b1;
                end
        end

        always @(negedge clk) begin
                if (!rst) begin
                        assert (y_valid === m_valid && busy === m_busy) else begin
                                err_timing++;
                                $display("ERR %0t: y_valid %b busy %b, expected %b %b",
                                        $time, y_valid, busy, m_valid, m_busy);
                        end
                        if (m_valid) begin
                                n_checked++;
                                assert (y_out === sample_t'(m_pred)) else begin
                                        err_value++;
                                        $display("ERR %0t: y_out %0d, expected %0d",
                                                $time, y_out, m_pred);
                                end
                        end
                        // latency is measured on the DUT pulse itself
                        if (y_valid === 1'b1 && !m_paused) begin
                                assert (cycle - m_acc_cycle + 1 == valid_latency) else begin
                                        err_timing++;
                                        $display("ERR %0t: latency %0d, expected %0d", $time,
                                                cycle - m_acc_cycle + 1, valid_latency);
                                end
                        end
                end
        end

        task automatic apply_reset();
                rst = 1'b1;
                enable = 1'b1;
                x_ready = 1'b0;
                repeat (2) @(negedge clk);
                rst = 1'b0;
        endtask

        task automatic check_reset_state();
                assert (y_valid === 1'b0 && busy === 1'b0 && y_out === '0) else begin
                        err_value++;
                        $display("ERR %0t: after reset y_valid %b busy %b y_out %0d",
                                $time, y_valid, busy, y_out);
                end
        endtask

        // called on a falling edge, returns on the falling edge that shows y_valid
        task automatic send_sample(input sample_t v, input bit with_pause, input bit with_pulses);
                logic [31:0] r;
                enable = 1'b1;
                x_ready = 1'b1;
                x_in = v;
                @(negedge clk);
                x_ready = 1'b0;
                while (!y_valid) begin
                        next_rand(r);
                        if (with_pulses) begin
                                x_ready = r[0];
                                x_in = sample_t'(r[15:8]);
                        end
                        if (with_pause)
                                enable = (r[3:2] != 2'b00);
                        @(negedge clk);
                end
                x_ready = 1'b0;
                enable = 1'b1;
        endtask

        initial begin
                while (cycle < timeout_cycles)
                        @(posedge clk);
                $display("timeout: run did not finish within %0d cycles", timeout_cycles);
                $display("tests failed");
                $finish;
        end

        initial begin
                logic [31:0] r;
                rst = 1'b1;
                enable = 1'b1;
                x_ready = 1'b0;
                x_in = '0;
                rng = seed;
                apply_reset();
                check_reset_state();
                send_sample(8'sd0, 1'b0, 1'b0);
                for (int i = 0; i < 200; i++) begin
                        next_rand(r);
                        send_sample(sample_t'(r[7:0]), 1'b0, 1'b0);
                end
                // drive the hidden clamp and the output saturation
                for (int i = 0; i < 32; i++)
                        send_sample((i < 16) ? -8'sd128 : 8'sd127, 1'b0, 1'b0);
                for (int i = 0; i < 20; i++) begin
                        next_rand(r);
                        send_sample(sample_t'(r[7:0]), 1'b0, 1'b1);
                end
                for (int i = 0; i < 30; i++) begin
                        next_rand(r);
                        send_sample(sample_t'(r[7:0]), 1'b1, 1'b0);
                end
                for (int i = 0; i < 3; i++) begin
                        next_rand(r);
                        send_sample(sample_t'(r[7:0]), 1'b0, 1'b0);
                end
                // reset lands in the middle of an accumulation
                x_ready = 1'b1;
                x_in = 8'sd100;
                @(negedge clk);
                x_ready = 1'b0;
                repeat (8) @(negedge clk);
                apply_reset();
                check_reset_state();
                send_sample(8'sd0, 1'b0, 1'b0);
                next_rand(r);
                send_sample(sample_t'(r[7:0]), 1'b0, 1'b0);
                @(negedge clk);
                assert (n_checked == n_samples - 1) else begin
                        err_timing++;
                        $display("missing predictions: saw %0d of %0d", n_checked, n_samples - 1);
                end
                $display("checked %0d predictions, %0d value errors, %0d timing errors",
                        n_checked, err_value, err_timing);
                if (err_value + err_timing == 0) begin
                        $display("all tests passed");
                end else begin
                        $display("tests failed");
                end
                $finish;
        end

endmodule

//--- weights.hex
// one signed Q2.6 byte per line: b1[0..4], w1[0..4][0..15] neuron-major, b2, w2[0..4]
08
F4
10
FA
03
0C
F6
09
13
FB
07
EE
04
0E
FD
F2
0A
05
F8
11
FE
F3
0D
FA
06
12
F5
03
EF
0B
08
F9
14
FC
02
F1
0A
07
07
F0
0C
FE
10
F7
05
EB
0D
01
F6
0F
04
FA
09
FC
11
08
F2
0A
FD
13
F5
06
EE
0C
03
F8
10
05
F4
10
FB
0E
02
F4
09
FE
12
F7
06
0B
F1
04
0D
F9
EC
06
30
C8
28
3A
D0

//--- filelist.f
src/nar_pkg.sv
src/nar_ctrl.sv
src/tap_counter.sv
src/weight_rom.sv
src/tap_delay_line.sv
src/hidden_layer.sv
src/output_layer.sv
src/narnet_top.sv
bench/narnet_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the narnet testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module narnet_tb \
        -f filelist.f -o narnet_sim
./obj_dir/narnet_sim > sim.log 2>&1
cat sim.log
if grep -q "tests failed" sim.log; then
        echo "simulation reported failure"
        exit 1
fi
echo "simulation finished without failure"
